//--- Makefile
TOOL       = verilator
FLIST      = all.f
TOP        = tb_rom_check
RTL_TOP    = rom_check_top
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

sim:
	rm -f $(LOG)
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- all.f
+incdir+.
rom_check_pkg.sv
rom_check_seq.sv
rom_check_lane.sv
rom_check_verdict.sv
rom_check_top.sv
tb_rom_model.sv
tb_rom_check.sv

//--- rom_check_lane.sv
// One hash lane: mixes low ROM words into a digest word and compares it with its expected word
`timescale 1ns/1ns
`include "rom_check_settings.svh"

module rom_check_lane
  import rom_check_pkg::*;
#(
  parameter int LaneIdx = 0
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  lane_feed_t feed_i,
  output rom_word_t  digest_o,
  output lane_res_t  res_o
);

  // Each lane rotates by a different amount so the lanes diverge
  localparam int Rot = (LaneIdx + 1) % 32;
  localparam rom_word_t InitVal = `ROM_CHECK_LANE_INIT ^ rom_word_t'(LaneIdx);

  rom_word_t digest_q, exp_q;
  rom_word_t mix_in, mixed;
  logic      my_top;
  logic      seen_q, done_q, match_q;

  // Rotate-xor-add step
  assign mix_in = digest_q ^ feed_i.word;
  assign mixed  = ((mix_in << Rot) | (mix_in >> (32 - Rot))) + `ROM_CHECK_LANE_ADD;

  assign my_top = feed_i.valid && feed_i.is_top && (feed_i.top_idx == lane_idx_t'(LaneIdx));

  always_ff @(posedge clk_i) begin
    if (feed_i.clear) begin
      digest_q <= InitVal;
    end else if (feed_i.valid && feed_i.is_low) begin
      digest_q <= mixed;
    end
    if (my_top) begin
      exp_q <= feed_i.word;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seen_q  <= 1'b0;
      done_q  <= 1'b0;
      match_q <= 1'b0;
    end else if (feed_i.clear) begin
      seen_q  <= 1'b0;
      done_q  <= 1'b0;
      match_q <= 1'b0;
    end else begin
      if (my_top) begin
        seen_q <= 1'b1;
      end
      // Match needs the expected word to have actually been read
      if (feed_i.check) begin
        done_q  <= 1'b1;
        match_q <= seen_q && (exp_q == digest_q);
      end
    end
  end

  assign digest_o = digest_q;
  assign res_o    = '{done: done_q, match: match_q};

  // The sequencer must never ask for a compare while a word is still arriving
  assert property (@(posedge clk_i) disable iff (!rst_ni) feed_i.check |-> !feed_i.valid);

endmodule

//--- rom_check_pkg.sv
// Shared types for the ROM integrity checker, imported by every RTL module and the testbench
`include "rom_check_settings.svh"

package rom_check_pkg;

  // One ROM word, also the size of one digest word
  typedef logic [31:0] rom_word_t;

  // Word address on the bus and the index of a digest lane
  typedef logic [`ROM_CHECK_ADDR_W-1:0] wb_addr_t;
  typedef logic [`ROM_CHECK_IDX_W-1:0]  lane_idx_t;

  // Wishbone classic, master to slave
  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
  } wb_req_t;

  // Wishbone classic, slave to master
  typedef struct packed {
    logic      ack;
    logic      err;
    rom_word_t dat;
  } wb_rsp_t;

  // Broadcast from the sequencer to every lane
  typedef struct packed {
    logic      valid;
    logic      is_low;
    logic      is_top;
    lane_idx_t top_idx;
    logic      clear;
    logic      check;
    rom_word_t word;
  } lane_feed_t;

  // Per-lane verdict, match only means something once done is set
  typedef struct packed {
    logic done;
    logic match;
  } lane_res_t;

  // Checker FSM states; the order is the normal path, Invalid is terminal
  typedef enum logic [2:0] {
    ReadLow,
    ReadHigh,
    Checking,
    Done,
    Invalid
  } seq_state_e;

endpackage

//--- rom_check_seq.sv
// Checker FSM that reads the whole ROM over Wishbone and broadcasts each word to the hash lanes
`timescale 1ns/1ns

module rom_check_seq
  import rom_check_pkg::*;
#(
  parameter int RomDepth = 32,
  parameter int TopCount = 4
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  output wb_req_t    wb_req_o,
  input  wb_rsp_t    wb_rsp_i,
  output lane_feed_t feed_o,
  input  logic       verdict_done_i,
  output logic       in_done_o,
  output logic       bus_owned_o,
  output logic       alert_o
);

  // First expected-digest address, and the last word of each region
  localparam wb_addr_t TopStart = wb_addr_t'(RomDepth - TopCount);
  localparam wb_addr_t LastLow  = wb_addr_t'(RomDepth - TopCount - 1);
  localparam wb_addr_t LastAddr = wb_addr_t'(RomDepth - 1);

  seq_state_e state_d, state_q;
  wb_addr_t   addr_q;
  wb_addr_t   top_off;
  logic       cyc_q, stb_q;
  logic       check_q, clear_q;
  logic       xfer_ack, xfer_err, stray_rsp, early_verdict;

  // A transfer ends with ack or err while stb is up; err wins if both appear
  assign xfer_ack  = stb_q & wb_rsp_i.ack & ~wb_rsp_i.err;
  assign xfer_err  = stb_q & wb_rsp_i.err;
  // The slave must stay quiet while no strobe is out
  assign stray_rsp = ~stb_q & (wb_rsp_i.ack | wb_rsp_i.err);
  // Lanes can only finish after we have pulsed check
  assign early_verdict = verdict_done_i & ~(state_q inside {Checking, Done});

  always_comb begin
    state_d = state_q;
    case (state_q)
      ReadLow: begin
        if (xfer_ack && addr_q == LastLow) begin
          state_d = ReadHigh;
        end
      end
      ReadHigh: begin
        if (xfer_ack && addr_q == LastAddr) begin
          state_d = Checking;
        end
      end
      Checking: begin
        if (verdict_done_i) begin
          state_d = Done;
        end
      end
      Done: begin
        state_d = Done;
      end
      default: begin
        state_d = Invalid;
      end
    endcase
    // Any bus error or consistency fault is terminal
    if (xfer_err || stray_rsp || early_verdict) begin
      state_d = Invalid;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ReadLow;
      addr_q  <= '0;
      cyc_q   <= 1'b0;
      stb_q   <= 1'b0;
      check_q <= 1'b0;
      clear_q <= 1'b1;
    end else begin
      state_q <= state_d;
      // Lanes restart in the first cycle out of reset, before any word can arrive
      clear_q <= 1'b0;
      // One-cycle check pulse right after the final word is taken
      check_q <= (state_q == ReadHigh) && (state_d == Checking);
      if (state_d inside {ReadLow, ReadHigh}) begin
        // Cyc stays up for the whole read, stb gaps one cycle after every ack
        cyc_q <= 1'b1;
        if (xfer_ack) begin
          stb_q  <= 1'b0;
          addr_q <= addr_q + 1'b1;
        end else if (!stb_q) begin
          stb_q <= 1'b1;
        end
      end else begin
        cyc_q <= 1'b0;
        stb_q <= 1'b0;
      end
    end
  end

  assign wb_req_o = '{cyc: cyc_q, stb: stb_q, we: 1'b0, adr: addr_q};

  // Offset into the digest region, only meaningful for top addresses
  assign top_off = addr_q - TopStart;

  // The returned word goes to all lanes in the ack cycle itself
  assign feed_o.valid   = xfer_ack;
  assign feed_o.is_low  = xfer_ack & (addr_q < TopStart);
  assign feed_o.is_top  = xfer_ack & (addr_q >= TopStart);
  assign feed_o.top_idx = lane_idx_t'(top_off);
  assign feed_o.clear   = clear_q;
  assign feed_o.check   = check_q;
  assign feed_o.word    = wb_rsp_i.dat;

  // Done is reported in the same cycle the verdict arrives, so the flag is not a cycle late
  assign in_done_o = (state_q == Done) || (state_q == Checking && verdict_done_i);

  // We own the ROM bus from reset until the check completes
  assign bus_owned_o = ~in_done_o;

  assign alert_o = (state_q == Invalid);

  // A strobe is only ever raised inside an open cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni) wb_req_o.stb |-> wb_req_o.cyc);

  // While the slave holds us in wait states the address must not move
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wb_req_o.stb && !wb_rsp_i.ack && !wb_rsp_i.err) |=> $stable(wb_req_o.adr));

  // Every expected word must land in an existing lane
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (feed_o.valid && feed_o.is_top) |-> (int'(feed_o.top_idx) < TopCount));

endmodule

//--- rom_check_settings.svh
// Build-time constants for the ROM integrity checker, included by the package, lanes, top and TB
`ifndef ROM_CHECK_SETTINGS_SVH
`define ROM_CHECK_SETTINGS_SVH

// Number of 32-bit words in the ROM image
`define ROM_CHECK_DEPTH 32

// Number of expected-digest words at the top of ROM, one hash lane per word
`define ROM_CHECK_TOP 4

// Word address width on the Wishbone port and width of a lane index
`define ROM_CHECK_ADDR_W 16
`define ROM_CHECK_IDX_W 8

// Lane mix constants; lane i starts from LANE_INIT xor i
`define ROM_CHECK_LANE_INIT 32'h6a09e667
`define ROM_CHECK_LANE_ADD 32'h9e3779b9

`endif

//--- rom_check_top.sv
// Top level of the ROM integrity checker: sequencer, one hash lane per digest word and the verdict
`timescale 1ns/1ns
`include "rom_check_settings.svh"

module rom_check_top
  import rom_check_pkg::*;
#(
  parameter int RomDepth = `ROM_CHECK_DEPTH,
  parameter int TopCount = `ROM_CHECK_TOP
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  output wb_req_t                   wb_req_o,
  input  wb_rsp_t                   wb_rsp_i,
  output logic                      done_o,
  output logic                      good_o,
  output logic                      alert_o,
  output logic                      bus_owned_o,
  output rom_word_t [TopCount-1:0] digest_o
);

  lane_feed_t               feed;
  lane_res_t [TopCount-1:0] lane_res;
  logic                     verdict_done;
  logic                     seq_alert, verdict_alert;

  rom_check_seq #(
    .RomDepth (RomDepth),
    .TopCount (TopCount)
  ) u_seq (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .wb_req_o       (wb_req_o),
    .wb_rsp_i       (wb_rsp_i),
    .feed_o         (feed),
    .verdict_done_i (verdict_done),
    .in_done_o      (done_o),
    .bus_owned_o    (bus_owned_o),
    .alert_o        (seq_alert)
  );

  // Every lane sees the same broadcast and picks its own expected word
  for (genvar i = 0; i < TopCount; i++) begin : g_lane
    rom_check_lane #(
      .LaneIdx (i)
    ) u_lane (
      .clk_i    (clk_i),
      .rst_ni   (rst_ni),
      .feed_i   (feed),
      .digest_o (digest_o[i]),
      .res_o    (lane_res[i])
    );
  end

  rom_check_verdict #(
    .TopCount (TopCount)
  ) u_verdict (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .res_i   (lane_res),
    .done_o  (verdict_done),
    .good_o  (good_o),
    .alert_o (verdict_alert)
  );

  assign alert_o = seq_alert | verdict_alert;

endmodule

//--- rom_check_verdict.sv
// Gathers all lane results into one registered done/good pair and flags inconsistent lanes
`timescale 1ns/1ns

module rom_check_verdict
  import rom_check_pkg::*;
#(
  parameter int TopCount = 4
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  lane_res_t [TopCount-1:0] res_i,
  output logic                      done_o,
  output logic                      good_o,
  output logic                      alert_o
);

  logic [TopCount-1:0] done_bits, match_bits;
  lane_res_t [TopCount-1:0] res_q;
  logic all_done, any_done, changed;
  logic done_q, good_q, alert_q;

  always_comb begin
    for (int i = 0; i < TopCount; i++) begin
      done_bits[i]  = res_i[i].done;
      match_bits[i] = res_i[i].match;
    end
  end

  assign all_done = &done_bits;
  assign any_done = |done_bits;
  // After the verdict is taken no lane may change its answer
  assign changed  = done_q && (res_i != res_q);

  // Snapshot of last cycle's results for the change check
  always_ff @(posedge clk_i) begin
    res_q <= res_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q  <= 1'b0;
      good_q  <= 1'b0;
      alert_q <= 1'b0;
    end else begin
      if (all_done && !done_q) begin
        done_q <= 1'b1;
        good_q <= &match_bits;
      end
      // Lanes all see the same check pulse, so a partial done is a fault
      if ((any_done && !all_done) || changed) begin
        alert_q <= 1'b1;
      end
    end
  end

  assign done_o  = done_q;
  assign good_o  = good_q;
  assign alert_o = alert_q;

endmodule

//--- tb_rom_check.sv
// Testbench for the ROM integrity checker; simulate with tb_rom_check as the top module
`timescale 1ns/1ns
`include "rom_check_settings.svh"

module tb_rom_check
  import rom_check_pkg::*;
();

  localparam int Depth    = `ROM_CHECK_DEPTH;
  localparam int Top      = `ROM_CHECK_TOP;
  localparam int LowWords = Depth - Top;
  localparam int MaxWait  = 3;
  // Five runs of every word at full wait, plus reset and the post-done checks, plus margin
  localparam int TimeoutCycles = 5 * (Depth * (MaxWait + 2) + 60) + 200;

  logic                clk_i = 1'b0;
  logic                rst_ni;
  wb_req_t             wb_req;
  wb_rsp_t             wb_rsp;
  logic                done, good, alert, bus_owned;
  rom_word_t [Top-1:0] digest;
  logic                wait_en;
  int                  err_addr;
  logic                order_fault;
  int                  resp_cnt;

  rom_word_t img [Depth];
  int  cyc_cnt = 0;
  int  err_cnt = 0;
  int  pass_cnt = 0;
  int  fail_cnt = 0;
  // Cycle numbers at which the monitor saw each event
  bit  done_seen, alert_seen;
  int  last_ack_cyc, err_cyc, done_cyc, alert_cyc;
  // Words the checker has taken since the last reset
  int  ack_cnt = 0;

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) cyc_cnt <= cyc_cnt + 1;

  rom_check_top #(
    .RomDepth (Depth),
    .TopCount (Top)
  ) dut_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .wb_req_o    (wb_req),
    .wb_rsp_i    (wb_rsp),
    .done_o      (done),
    .good_o      (good),
    .alert_o     (alert),
    .bus_owned_o (bus_owned),
    .digest_o    (digest)
  );

  tb_rom_model #(
    .RomDepth (Depth)
  ) u_rom (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .wb_req_i      (wb_req),
    .wb_rsp_o      (wb_rsp),
    .wait_en_i     (wait_en),
    .err_addr_i    (err_addr),
    .order_fault_o (order_fault),
    .resp_cnt_o    (resp_cnt)
  );

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
      err_cnt++;
    end
  endtask

  // Applies the lane rule to every low word and reports whether the top words hold the digest
  function automatic bit ref_digest(output rom_word_t [Top-1:0] dig);
    rom_word_t d;
    rom_word_t x;
    int        r;
    bit        ok;
    ok = 1'b1;
    for (int l = 0; l < Top; l++) begin
      d = `ROM_CHECK_LANE_INIT ^ 32'(l);
      r = (l + 1) % 32;
      for (int a = 0; a < LowWords; a++) begin
        x = d ^ img[a];
        d = ((x << r) | (x >> (32 - r))) + `ROM_CHECK_LANE_ADD;
      end
      dig[l] = d;
      if (img[LowWords + l] !== d) begin
        ok = 1'b0;
      end
    end
    return ok;
  endfunction

  // Samples mid-cycle, where every DUT output has settled
  always @(negedge clk_i) begin : monitor
    bit owned_exp;
    if (!rst_ni) begin
      done_seen  = 1'b0;
      alert_seen = 1'b0;
      ack_cnt    = 0;
    end else begin
      if (wb_req.stb && wb_rsp.ack) begin
        last_ack_cyc = cyc_cnt;
        ack_cnt++;
      end
      if (wb_req.stb && wb_rsp.err) err_cyc = cyc_cnt;
      // Done is sticky
      if (done_seen) check_val("done_o", done, 1'b1);
      // The bus is handed over three cycles after the ack of the last ROM word
      owned_exp = !(ack_cnt == Depth && cyc_cnt >= last_ack_cyc + 3);
      check_val("bus_owned_o", bus_owned, owned_exp);
      if (done && !done_seen) begin
        done_seen = 1'b1;
        done_cyc  = cyc_cnt;
      end
      if (alert && !alert_seen) begin
        alert_seen = 1'b1;
        alert_cyc  = cyc_cnt;
      end
    end
  end

  task automatic apply_reset;
    @(posedge clk_i);
    #1 rst_ni = 1'b0;
    repeat (10) @(negedge clk_i);
    check_val("wb_req_o.cyc in reset", wb_req.cyc, 1'b0);
    check_val("done_o in reset", done, 1'b0);
    check_val("good_o in reset", good, 1'b0);
    check_val("alert_o in reset", alert, 1'b0);
    @(posedge clk_i);
    #1 rst_ni = 1'b1;
  endtask

  task automatic load_rom;
    for (int a = 0; a < Depth; a++) begin
      u_rom.mem[a] = img[a];
    end
  endtask

  // Resets, lets the checker read the ROM and returns once it finishes or alerts
  task automatic run_rom(input bit use_waits, input int bad_addr);
    wait_en  = use_waits;
    err_addr = bad_addr;
    apply_reset;
    while (!done && !alert) @(negedge clk_i);
    // One more sample so the monitor has logged the final cycle
    @(negedge clk_i);
  endtask

  task automatic check_done(input rom_word_t [Top-1:0] exp_dig, input bit exp_good);
    check_val("done_o latency after last ack", done_cyc - last_ack_cyc, 3);
    check_val("good_o", good, exp_good);
    check_val("alert_o", alert, 1'b0);
    for (int i = 0; i < Top; i++) begin
      check_val($sformatf("digest_o[%0d]", i), digest[i], exp_dig[i]);
    end
    // The verdict and digest must hold while nothing else happens
    repeat (5) @(negedge clk_i);
    check_val("good_o held", good, exp_good);
    for (int i = 0; i < Top; i++) begin
      check_val($sformatf("digest_o[%0d] held", i), digest[i], exp_dig[i]);
    end
  endtask

  task automatic finish_test(input int num, input string what, input int errs_before);
    if (err_cnt == errs_before) begin
      pass_cnt++;
      $display("Test %0d pass: %s", num, what);
    end else begin
      fail_cnt++;
      $display("Test %0d fail: %s, %0d errors", num, what, err_cnt - errs_before);
    end
  endtask

  initial begin : watchdog
    while (cyc_cnt < TimeoutCycles) @(posedge clk_i);
    $display("Timeout: the checker did not finish within %0d cycles", TimeoutCycles);
    $display("Result: FAILED");
    $finish;
  end

  initial begin : tests
    rom_word_t [Top-1:0] dig_base;
    rom_word_t [Top-1:0] dig_ref;
    bit                  good_ref;
    int                  errs;
    rst_ni   = 1'b0;
    wait_en  = 1'b0;
    err_addr = -1;

    // Fill pattern mixes the whole address, then the top words get the true digest
    for (int a = 0; a < Depth; a++) begin
      img[a] = (32'(a) * 32'h0100_0193) ^ 32'hc3a5_0f1e;
    end
    good_ref = ref_digest(dig_base);
    for (int i = 0; i < Top; i++) begin
      img[LowWords + i] = dig_base[i];
    end
    good_ref = ref_digest(dig_ref);

    errs = err_cnt;
    load_rom;
    run_rom(1'b0, -1);
    check_done(dig_base, good_ref);
    check_val("bus_owned_o after done", bus_owned, 1'b0);
    finish_test(1, "correct digest without wait states", errs);

    errs = err_cnt;
    run_rom(1'b1, -1);
    check_done(dig_base, 1'b1);
    check_val("order_fault", order_fault, 1'b0);
    check_val("resp_cnt", resp_cnt, Depth);
    finish_test(2, "correct digest with wait states", errs);

    // A changed low word moves the digest away from the stored one
    errs = err_cnt;
    img[5]   = img[5] ^ 32'h0000_0100;
    good_ref = ref_digest(dig_ref);
    load_rom;
    run_rom(1'b1, -1);
    check_done(dig_ref, good_ref);
    finish_test(3, "flipped low word", errs);

    errs = err_cnt;
    img[5]            = img[5] ^ 32'h0000_0100;
    img[LowWords + 2] = img[LowWords + 2] ^ 32'h8000_0000;
    load_rom;
    run_rom(1'b0, -1);
    check_done(dig_base, 1'b0);
    finish_test(4, "flipped expected word", errs);

    // Bus error in the middle of the low region
    errs = err_cnt;
    img[LowWords + 2] = img[LowWords + 2] ^ 32'h8000_0000;
    load_rom;
    run_rom(1'b1, 7);
    check_val("alert_o", alert, 1'b1);
    check_val("alert_o latency after err", alert_cyc - err_cyc, 1);
    check_val("wb_req_o.cyc after err", wb_req.cyc, 1'b0);
    check_val("done_o after err", done, 1'b0);
    repeat (20) begin
      @(negedge clk_i);
      check_val("done_o after err", done, 1'b0);
      check_val("alert_o after err", alert, 1'b1);
      check_val("wb_req_o.cyc after err", wb_req.cyc, 1'b0);
    end
    apply_reset;
    finish_test(5, "bus error raises alert", errs);

    $display("Tests passed %0d, failed %0d, check errors %0d", pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- tb_rom_model.sv
// Testbench Wishbone slave ROM with random wait states, error injection and an address order check
`timescale 1ns/1ns

module tb_rom_model
  import rom_check_pkg::*;
#(
  parameter int RomDepth = 32
) (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  wb_req_t wb_req_i,
  output wb_rsp_t wb_rsp_o,
  input  logic    wait_en_i,
  input  int      err_addr_i,
  output logic    order_fault_o,
  output int      resp_cnt_o
);

  // ROM contents, written by the testbench top before each run
  rom_word_t   mem [RomDepth];
  wb_rsp_t     rsp = '0;
  logic [15:0] lfsr = 16'd27085;
  logic        busy = 1'b0;
  int          wait_left = 0;
  int          next_addr = 0;
  logic        order_fault = 1'b0;
  int          resp_cnt = 0;

  // Fibonacci LFSR, taps 16 14 13 11; the new bit enters at bit 0
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // Reset is sampled on the edge, the bus a short delay later once the master has settled
  always @(posedge clk_i) begin : respond
    logic in_reset;
    in_reset = !rst_ni;
    #1;
    if (in_reset) begin
      rsp         = '0;
      busy        = 1'b0;
      wait_left   = 0;
      next_addr   = 0;
      order_fault = 1'b0;
      resp_cnt    = 0;
    end else if (rsp.ack || rsp.err) begin
      // The master took the response on this edge, so the strobe is already down
      rsp = '0;
    end else if (wb_req_i.cyc && wb_req_i.stb) begin
      if (!busy) begin
        busy      = 1'b1;
        wait_left = 0;
        // Two LFSR bits give 0 to 3 wait states
        if (wait_en_i) begin
          lfsr      = lfsr_step(lfsr);
          wait_left = int'(lfsr[0]);
          lfsr      = lfsr_step(lfsr);
          wait_left = wait_left * 2 + int'(lfsr[0]);
        end
      end
      if (wait_left > 0) begin
        wait_left--;
      end else begin
        busy = 1'b0;
        // Words must come in strictly rising order, each exactly once
        if (int'(wb_req_i.adr) != next_addr) begin
          order_fault = 1'b1;
        end
        next_addr++;
        resp_cnt++;
        if (int'(wb_req_i.adr) == err_addr_i) begin
          rsp.err = 1'b1;
        end else begin
          rsp.ack = 1'b1;
          rsp.dat = (int'(wb_req_i.adr) < RomDepth) ? mem[wb_req_i.adr] : '0;
        end
      end
    end
  end

  assign wb_rsp_o      = rsp;
  assign order_fault_o = order_fault;
  assign resp_cnt_o    = resp_cnt;

endmodule
